// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= i8080_exec_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/alu.sv
module alu (
  input  i8080_pkg::byte_t     op_a,
  input  i8080_pkg::byte_t     op_b,
  input  i8080_pkg::alu_grp_e  grp,
  input  i8080_pkg::alu_op_e   op,
  input  i8080_pkg::byte_t     flags_in,
  output i8080_pkg::byte_t     result,
  output i8080_pkg::byte_t     flags_out
);
  logic             cin;
  logic [8:0]       sum;
  logic             set_szp;
  i8080_pkg::byte_t daa_val;
  i8080_pkg::byte_t daa_flags;

  // adc and sbb take the carry, bit 1 selects subtract, bit 8 is carry/borrow
  assign cin = ~op[2] & op[0] & flags_in[i8080_pkg::FLAG_C];
  assign sum = op[1] ? ({1'b0, op_a} - {1'b0, op_b} - 9'(cin))
                     : ({1'b0, op_a} + {1'b0, op_b} + 9'(cin));

  always_comb begin : daa
    daa_val   = op_a;
    daa_flags = flags_in;
    if (op_a[3:0] > 4'd9 || flags_in[i8080_pkg::FLAG_A]) begin
      daa_val                       = daa_val + 8'h06;
      daa_flags[i8080_pkg::FLAG_A]  = 1'b1;
    end
    if (daa_val[7:4] > 4'd9 || flags_in[i8080_pkg::FLAG_C]) begin
      daa_val                       = daa_val + 8'h60;  // high nibble only
      daa_flags[i8080_pkg::FLAG_C]  = 1'b1;
    end
  end

  always_comb begin
    result    = op_a;
    flags_out = flags_in;
    set_szp   = 1'b0;
    case (grp)
      i8080_pkg::GRP_ARITH: begin
        set_szp = 1'b1;
        case (op)
          i8080_pkg::ALU_ANA: result = op_a & op_b;
          i8080_pkg::ALU_XRA: result = op_a ^ op_b;
          i8080_pkg::ALU_ORA: result = op_a | op_b;
          default: {flags_out[i8080_pkg::FLAG_C], result} = sum;  // ac left alone
        endcase
        if (op inside {i8080_pkg::ALU_ANA, i8080_pkg::ALU_XRA, i8080_pkg::ALU_ORA}) begin
          flags_out[i8080_pkg::FLAG_C] = 1'b0;
          flags_out[i8080_pkg::FLAG_A] = 1'b0;
        end
      end
      i8080_pkg::GRP_ALT: begin
        case (op)
          3'd0: {flags_out[i8080_pkg::FLAG_C], result} = {op_a[7], op_a[6:0], op_a[7]};  // rlc
          3'd1: {result, flags_out[i8080_pkg::FLAG_C]} = {op_a[0], op_a};  // rrc
          3'd2: {flags_out[i8080_pkg::FLAG_C], result} = {op_a, flags_in[i8080_pkg::FLAG_C]};
          3'd3: {result, flags_out[i8080_pkg::FLAG_C]} = {flags_in[i8080_pkg::FLAG_C], op_a};
          3'd4: begin  // daa
            result    = daa_val;
            flags_out = daa_flags;
          end
          3'd5: result = ~op_a;  // cma
          3'd6: flags_out[i8080_pkg::FLAG_C] = 1'b1;  // stc
          default: flags_out[i8080_pkg::FLAG_C] = ~flags_in[i8080_pkg::FLAG_C];  // cmc
        endcase
      end
      i8080_pkg::GRP_INCDEC: begin
        result  = op[0] ? op_b - 8'd1 : op_b + 8'd1;
        set_szp = 1'b1;
      end
      default: ;
    endcase
    if (set_szp) begin
      flags_out[i8080_pkg::FLAG_S] = result[7];
      flags_out[i8080_pkg::FLAG_Z] = result == 8'd0;
      flags_out[i8080_pkg::FLAG_P] = ~^result;  // even parity
    end
  end

endmodule

// File: hdl/i8080_exec.sv
module i8080_exec #(
  parameter int INSTR_DEPTH    = 4,
  parameter int RETIRE_CREDITS = 2
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    instr_valid,
  input  i8080_pkg::instr_word_t  instr_data,
  output logic                    instr_credit,
  output logic                    retire_valid,
  output i8080_pkg::retire_t      retire_data,
  input  logic                    retire_credit
);
  i8080_pkg::instr_word_t head;
  logic                   not_empty;
  logic                   pop;
  i8080_pkg::op_class_e   op_class;
  i8080_pkg::reg_code_t   sss;
  i8080_pkg::reg_code_t   ddd;
  i8080_pkg::rp_code_t    rp;
  i8080_pkg::alu_grp_e    alu_grp;
  i8080_pkg::alu_op_e     alu_op;
  i8080_pkg::byte_t       src_val;
  i8080_pkg::byte_t       dst_val;
  i8080_pkg::byte_t       alu_op_b;
  i8080_pkg::byte_t       alu_result;
  i8080_pkg::byte_t       alu_flags;
  i8080_pkg::byte_t       acc;
  i8080_pkg::byte_t       flags;
  logic                   reg_wen;
  i8080_pkg::byte_t       reg_wdata;
  i8080_pkg::word_t       bc;
  i8080_pkg::word_t       de;
  i8080_pkg::word_t       hl;
  i8080_pkg::word_t       sp;

  instr_buffer #(.INSTR_DEPTH(INSTR_DEPTH)) i_instr_buffer (
    .clk(clk), .rst_n(rst_n), .push(instr_valid), .push_data(instr_data),
    .pop(pop), .head(head), .not_empty(not_empty), .credit(instr_credit)
  );

  instr_decoder i_instr_decoder (
    .opcode(head.opcode), .op_class(op_class), .sss(sss), .ddd(ddd), .rp(rp),
    .alu_grp(alu_grp), .alu_op(alu_op)
  );

  // inr/dcr work on ddd, immediates come from the word
  assign alu_op_b = (op_class == i8080_pkg::CLS_ALU_IMM) ? head.imm
                  : (op_class inside {i8080_pkg::CLS_INR, i8080_pkg::CLS_DCR}) ? dst_val
                  : src_val;

  alu i_alu (
    .op_a(acc), .op_b(alu_op_b), .grp(alu_grp), .op(alu_op), .flags_in(flags),
    .result(alu_result), .flags_out(alu_flags)
  );

  register_array i_register_array (
    .clk(clk), .rst_n(rst_n), .sss(sss), .ddd(ddd), .rp(rp), .op_class(op_class),
    .exec(pop), .acc(acc), .wen(reg_wen), .wdata(reg_wdata), .src_val(src_val),
    .dst_val(dst_val), .bc(bc), .de(de), .hl(hl), .sp(sp)
  );

  writeback #(.RETIRE_CREDITS(RETIRE_CREDITS)) i_writeback (
    .clk(clk), .rst_n(rst_n), .not_empty(not_empty), .head(head), .op_class(op_class),
    .alu_op(alu_op), .src_val(src_val), .alu_result(alu_result), .alu_flags(alu_flags),
    .bc(bc), .de(de), .hl(hl), .sp(sp), .retire_credit(retire_credit), .pop(pop),
    .acc(acc), .flags(flags), .reg_wen(reg_wen), .reg_wdata(reg_wdata),
    .retire_valid(retire_valid), .retire_data(retire_data)
  );

endmodule

// File: hdl/i8080_pkg.sv
package i8080_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [15:0] word_t;

  typedef struct packed {
    byte_t opcode;
    byte_t imm;  // only read by mvi and alu immediates
  } instr_word_t;

  typedef enum logic [3:0] {
    CLS_MOV, CLS_MVI, CLS_ALU_REG, CLS_ALU_IMM, CLS_ALU_ALT, CLS_INR,
    CLS_DCR, CLS_INX, CLS_DCX, CLS_XCHG, CLS_SPHL, CLS_NOP
  } op_class_e;

  // arith/logic names; the alt group reuses the same codes for rlc..cmc
  typedef enum logic [2:0] {
    ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBB, ALU_ANA, ALU_XRA, ALU_ORA, ALU_CMP
  } alu_op_e;

  typedef enum logic [1:0] {GRP_ARITH, GRP_ALT, GRP_INCDEC} alu_grp_e;

  typedef logic [2:0] reg_code_t;
  typedef logic [1:0] rp_code_t;

  localparam reg_code_t REG_M = 3'd6;
  localparam reg_code_t REG_A = 3'd7;

  localparam int FLAG_C = 0;
  localparam int FLAG_P = 2;
  localparam int FLAG_A = 4;
  localparam int FLAG_Z = 6;
  localparam int FLAG_S = 7;

  localparam byte_t FLAGS_RESET = 8'h02;  // bit 1 reads as one

  localparam byte_t REGS_RESET_B = 8'd1;
  localparam byte_t REGS_RESET_C = 8'd2;
  localparam byte_t REGS_RESET_D = 8'd3;
  localparam byte_t REGS_RESET_E = 8'd4;
  localparam byte_t REGS_RESET_H = 8'd5;
  localparam byte_t REGS_RESET_L = 8'd6;

  typedef struct packed {
    byte_t opcode;
    byte_t a;
    byte_t flags;
    word_t bc;
    word_t de;
    word_t hl;
    word_t sp;
  } retire_t;

endpackage

// File: hdl/instr_buffer.sv
module instr_buffer #(
  parameter int INSTR_DEPTH = 4
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    push,
  input  i8080_pkg::instr_word_t  push_data,
  input  logic                    pop,
  output i8080_pkg::instr_word_t  head,
  output logic                    not_empty,
  output logic                    credit
);
  localparam int PTR_W = $clog2(INSTR_DEPTH);
  localparam int CNT_W = $clog2(INSTR_DEPTH + 1);

  i8080_pkg::instr_word_t mem [INSTR_DEPTH];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  logic [CNT_W-1:0] count;
  logic             full;

  assign full      = count == CNT_W'(INSTR_DEPTH);
  assign not_empty = count != '0;
  assign head      = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(INSTR_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // depth need not be 2^n
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(INSTR_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count  <= count + CNT_W'(push) - CNT_W'(pop);
      credit <= pop;  // one credit back per word consumed
    end
  end

  // sender must respect its credits, writeback its head
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> not_empty);

endmodule

// File: hdl/instr_decoder.sv
module instr_decoder (
  input  i8080_pkg::byte_t      opcode,
  output i8080_pkg::op_class_e  op_class,
  output i8080_pkg::reg_code_t  sss,
  output i8080_pkg::reg_code_t  ddd,
  output i8080_pkg::rp_code_t   rp,
  output i8080_pkg::alu_grp_e   alu_grp,
  output i8080_pkg::alu_op_e    alu_op
);
  logic sss_mem;
  logic ddd_mem;

  assign sss     = opcode[2:0];
  assign ddd     = opcode[5:3];
  assign rp      = opcode[5:4];
  assign sss_mem = sss == i8080_pkg::REG_M;
  assign ddd_mem = ddd == i8080_pkg::REG_M;

  always_comb begin
    op_class = i8080_pkg::CLS_NOP;  // anything unlisted, incl. all M forms
    casez (opcode)
      8'b01_???_???: if (!sss_mem && !ddd_mem) op_class = i8080_pkg::CLS_MOV;
      8'b11_111_001: op_class = i8080_pkg::CLS_SPHL;
      8'b00_???_110: if (!ddd_mem) op_class = i8080_pkg::CLS_MVI;
      8'b11_101_011: op_class = i8080_pkg::CLS_XCHG;
      8'b10_???_???: if (!sss_mem) op_class = i8080_pkg::CLS_ALU_REG;
      8'b11_???_110: op_class = i8080_pkg::CLS_ALU_IMM;
      8'b00_???_111: op_class = i8080_pkg::CLS_ALU_ALT;
      8'b00_???_100: if (!ddd_mem) op_class = i8080_pkg::CLS_INR;
      8'b00_???_101: if (!ddd_mem) op_class = i8080_pkg::CLS_DCR;
      8'b00_??0_011: op_class = i8080_pkg::CLS_INX;
      8'b00_??1_011: op_class = i8080_pkg::CLS_DCX;
      default: ;
    endcase
  end

  always_comb begin
    alu_grp = i8080_pkg::GRP_ARITH;
    alu_op  = i8080_pkg::alu_op_e'(opcode[5:3]);
    case (op_class)
      i8080_pkg::CLS_ALU_ALT: alu_grp = i8080_pkg::GRP_ALT;
      i8080_pkg::CLS_INR, i8080_pkg::CLS_DCR: begin
        alu_grp = i8080_pkg::GRP_INCDEC;
        alu_op  = i8080_pkg::alu_op_e'({2'b00, opcode[0]});  // bit 0 set for dcr
      end
      default: ;
    endcase
  end

endmodule

// File: hdl/register_array.sv
module register_array (
  input  logic                  clk,
  input  logic                  rst_n,
  input  i8080_pkg::reg_code_t  sss,
  input  i8080_pkg::reg_code_t  ddd,
  input  i8080_pkg::rp_code_t   rp,
  input  i8080_pkg::op_class_e  op_class,
  input  logic                  exec,
  input  i8080_pkg::byte_t      acc,
  input  logic                  wen,
  input  i8080_pkg::byte_t      wdata,
  output i8080_pkg::byte_t      src_val,
  output i8080_pkg::byte_t      dst_val,
  output i8080_pkg::word_t      bc,
  output i8080_pkg::word_t      de,
  output i8080_pkg::word_t      hl,
  output i8080_pkg::word_t      sp
);
  i8080_pkg::word_t rp_val;
  i8080_pkg::word_t rp_new;

  function automatic i8080_pkg::byte_t rd_byte(input i8080_pkg::reg_code_t code);
    case (code)
      3'd0: rd_byte = bc[15:8];
      3'd1: rd_byte = bc[7:0];
      3'd2: rd_byte = de[15:8];
      3'd3: rd_byte = de[7:0];
      3'd4: rd_byte = hl[15:8];
      3'd5: rd_byte = hl[7:0];
      3'd7: rd_byte = acc;
      default: rd_byte = 8'h00;  // m never decodes to a live class
    endcase
  endfunction

  assign src_val = rd_byte(sss);
  assign dst_val = rd_byte(ddd);

  always_comb begin
    case (rp)
      2'd0: rp_val = bc;
      2'd1: rp_val = de;
      2'd2: rp_val = hl;
      default: rp_val = sp;
    endcase
  end

  assign rp_new = (op_class == i8080_pkg::CLS_DCX) ? rp_val - 16'd1 : rp_val + 16'd1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bc <= {i8080_pkg::REGS_RESET_B, i8080_pkg::REGS_RESET_C};
      de <= {i8080_pkg::REGS_RESET_D, i8080_pkg::REGS_RESET_E};
      hl <= {i8080_pkg::REGS_RESET_H, i8080_pkg::REGS_RESET_L};
      sp <= 16'h0000;
    end else if (exec) begin
      if (wen) begin
        case (ddd)  // code 7 falls through, a lives in writeback
          3'd0: bc[15:8] <= wdata;
          3'd1: bc[7:0]  <= wdata;
          3'd2: de[15:8] <= wdata;
          3'd3: de[7:0]  <= wdata;
          3'd4: hl[15:8] <= wdata;
          3'd5: hl[7:0]  <= wdata;
          default: ;
        endcase
      end
      case (op_class)
        i8080_pkg::CLS_INX, i8080_pkg::CLS_DCX: begin
          case (rp)
            2'd0: bc <= rp_new;
            2'd1: de <= rp_new;
            2'd2: hl <= rp_new;
            default: sp <= rp_new;
          endcase
        end
        i8080_pkg::CLS_XCHG: begin
          hl <= de;
          de <= hl;
        end
        i8080_pkg::CLS_SPHL: sp <= hl;
        default: ;
      endcase
    end
  end

  // writeback and decoder must agree that byte writes and pair ops never overlap
  a_wen_vs_pair: assert property (@(posedge clk) disable iff (!rst_n)
    wen |-> !(exec && (op_class inside {i8080_pkg::CLS_INX, i8080_pkg::CLS_DCX,
                                        i8080_pkg::CLS_XCHG, i8080_pkg::CLS_SPHL})));

endmodule

// File: hdl/writeback.sv
module writeback #(
  parameter int RETIRE_CREDITS = 2
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    not_empty,
  input  i8080_pkg::instr_word_t  head,
  input  i8080_pkg::op_class_e    op_class,
  input  i8080_pkg::alu_op_e      alu_op,
  input  i8080_pkg::byte_t        src_val,
  input  i8080_pkg::byte_t        alu_result,
  input  i8080_pkg::byte_t        alu_flags,
  input  i8080_pkg::word_t        bc,
  input  i8080_pkg::word_t        de,
  input  i8080_pkg::word_t        hl,
  input  i8080_pkg::word_t        sp,
  input  logic                    retire_credit,
  output logic                    pop,
  output i8080_pkg::byte_t        acc,
  output i8080_pkg::byte_t        flags,
  output logic                    reg_wen,
  output i8080_pkg::byte_t        reg_wdata,
  output logic                    retire_valid,
  output i8080_pkg::retire_t      retire_data
);
  localparam int CNT_W = $clog2(RETIRE_CREDITS + 1);

  logic [CNT_W-1:0] credits;
  logic             byte_dst;
  logic             alu_cls;
  logic             to_a;
  logic             flag_wr;
  i8080_pkg::byte_t wdata;
  i8080_pkg::byte_t a_next;
  i8080_pkg::byte_t opcode_q;

  assign pop = not_empty && (credits != '0);

  assign byte_dst = op_class inside {i8080_pkg::CLS_MOV, i8080_pkg::CLS_MVI,
                                     i8080_pkg::CLS_INR, i8080_pkg::CLS_DCR};
  assign alu_cls  = op_class inside {i8080_pkg::CLS_ALU_REG, i8080_pkg::CLS_ALU_IMM};

  always_comb begin
    case (op_class)
      i8080_pkg::CLS_MOV: wdata = src_val;
      i8080_pkg::CLS_MVI: wdata = head.imm;
      default:            wdata = alu_result;
    endcase
  end

  // cmp and stc/cmc only touch flags
  assign to_a = (byte_dst && head.opcode[5:3] == i8080_pkg::REG_A)
             || (alu_cls && alu_op != i8080_pkg::ALU_CMP)
             || (op_class == i8080_pkg::CLS_ALU_ALT && alu_op[2:1] != 2'b11);
  assign flag_wr = alu_cls || op_class inside {i8080_pkg::CLS_ALU_ALT,
                                               i8080_pkg::CLS_INR, i8080_pkg::CLS_DCR};

  assign a_next    = (pop && to_a) ? wdata : acc;
  assign reg_wen   = pop && byte_dst && !to_a;
  assign reg_wdata = wdata;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc          <= 8'h00;
      flags        <= i8080_pkg::FLAGS_RESET;
      credits      <= CNT_W'(RETIRE_CREDITS);
      retire_valid <= 1'b0;
    end else begin
      acc          <= a_next;
      if (pop && flag_wr) begin
        flags <= alu_flags;
      end
      credits      <= credits + CNT_W'(retire_credit) - CNT_W'(pop);
      retire_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      opcode_q <= head.opcode;
    end
  end

  // a, flags and pairs have all settled to the post-execute state by now
  assign retire_data = '{opcode: opcode_q, a: acc, flags: flags,
                         bc: bc, de: de, hl: hl, sp: sp};

  a_retire_credit: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid && !$past(retire_credit) |-> credits < CNT_W'(RETIRE_CREDITS));
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credits <= CNT_W'(RETIRE_CREDITS));  // receiver never returns extra

endmodule

// File: sim.f
hdl/i8080_pkg.sv
hdl/instr_buffer.sv
hdl/instr_decoder.sv
hdl/alu.sv
hdl/register_array.sv
hdl/writeback.sv
hdl/i8080_exec.sv
test/tb_clock.sv
test/i8080_exec_tb.sv

// File: test/exec_input.txt
# opcode imm | expected retire record: a flags bc de hl sp (all hex)
# one instruction per line, records retire in this order
00 00  00 02 0102 0304 0506 0000
3e 7f  7f 02 0102 0304 0506 0000
06 80  7f 02 8002 0304 0506 0000
80 00  ff 86 8002 0304 0506 0000
3c 00  00 46 8002 0304 0506 0000
c6 01  01 02 8002 0304 0506 0000
d6 02  ff 87 8002 0304 0506 0000
ce 00  00 47 8002 0304 0506 0000
3f 00  00 46 8002 0304 0506 0000
37 00  00 47 8002 0304 0506 0000
de 10  ef 83 8002 0304 0506 0000
48 00  ef 83 8080 0304 0506 0000
a1 00  80 82 8080 0304 0506 0000
ee ff  7f 02 8080 0304 0506 0000
b1 00  ff 86 8080 0304 0506 0000
fe ff  ff 46 8080 0304 0506 0000
07 00  ff 47 8080 0304 0506 0000
2f 00  00 47 8080 0304 0506 0000
1f 00  80 46 8080 0304 0506 0000
17 00  00 47 8080 0304 0506 0000
0f 00  00 46 8080 0304 0506 0000
3e 0b  0b 46 8080 0304 0506 0000
27 00  11 56 8080 0304 0506 0000
05 00  11 12 7f80 0304 0506 0000
0c 00  11 96 7f81 0304 0506 0000
b8 00  11 93 7f81 0304 0506 0000
b0 00  7f 02 7f81 0304 0506 0000
88 00  fe 82 7f81 0304 0506 0000
91 00  7d 06 7f81 0304 0506 0000
9a 00  7a 02 7f81 0304 0506 0000
23 00  7a 02 7f81 0304 0507 0000
1b 00  7a 02 7f81 0303 0507 0000
3b 00  7a 02 7f81 0303 0507 ffff
eb 00  7a 02 7f81 0507 0303 ffff
f9 00  7a 02 7f81 0507 0303 0303
7e 00  7a 02 7f81 0507 0303 0303
34 00  7a 02 7f81 0507 0303 0303
c3 34  7a 02 7f81 0507 0303 0303
01 55  7a 02 7f81 0507 0303 0303
76 00  7a 02 7f81 0507 0303 0303

// File: test/i8080_exec_tb.sv
module i8080_exec_tb;
  localparam int INSTR_DEPTH     = 4;
  localparam int RETIRE_CREDITS  = 2;
  localparam int CYCLES_PER_LINE = 40;
  localparam int DRAIN_CYCLES    = 8;
  localparam int IDLE_CYCLES     = 4;
  localparam logic [31:0] LFSR_SEED = 32'h9f02cfb3;
  localparam logic [31:0] LFSR_POLY = 32'h80200003;  // x^32+x^22+x^2+x+1

  logic                   clk;
  logic                   rst_n;
  logic                   instr_valid;
  i8080_pkg::instr_word_t instr_data;
  logic                   instr_credit;
  logic                   retire_valid;
  i8080_pkg::retire_t     retire_data;
  logic                   retire_credit;

  i8080_pkg::instr_word_t instr_q[$];
  i8080_pkg::retire_t     expect_q[$];
  int          n_lines = 0;
  logic        loaded = 1'b0;
  logic        error_seen = 1'b0;
  logic        timed_out = 1'b0;
  logic [31:0] lfsr = LFSR_SEED;
  int          send_idx = 0;
  int          send_credits = INSTR_DEPTH;
  int          send_gap = IDLE_CYCLES;  // core sits idle first
  int          credits_seen = 0;
  int          rx_idx = 0;
  int          credit_owed = 0;
  int          credit_gap = 0;
  int          credits_given = 0;

  tb_clock #(.PERIOD(8), .RESET_CYCLES(3)) i_tb_clock (.clk(clk), .rst_n(rst_n));

  i8080_exec #(.INSTR_DEPTH(INSTR_DEPTH), .RETIRE_CREDITS(RETIRE_CREDITS)) i_i8080_exec (
    .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr_data(instr_data),
    .instr_credit(instr_credit), .retire_valid(retire_valid), .retire_data(retire_data),
    .retire_credit(retire_credit)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    lfsr_step = state[0] ? ((state >> 1) ^ LFSR_POLY) : (state >> 1);
  endfunction

  function automatic int take_bits(input int count);
    int value;
    value = 0;
    for (int i = 0; i < count; i++) begin
      value = (value << 1) | int'(lfsr[0]);
      lfsr  = lfsr_step(lfsr);
    end
    return value;
  endfunction

  task automatic report_error(input string msg);
    if (!error_seen) $display("%s", msg);  // only the first one is shown
    error_seen = 1'b1;
  endtask

  task automatic compare_byte(input string name, input i8080_pkg::byte_t actual,
                              input i8080_pkg::byte_t expected, input int index);
    if (actual !== expected) begin
      report_error($sformatf("Mismatch %s in record %0d: got %02h, expected %02h",
                             name, index, actual, expected));
    end
  endtask

  task automatic compare_word(input string name, input i8080_pkg::word_t actual,
                              input i8080_pkg::word_t expected, input int index);
    if (actual !== expected) begin
      report_error($sformatf("Mismatch %s in record %0d: got %04h, expected %04h",
                             name, index, actual, expected));
    end
  endtask

  task automatic compare_retire(input i8080_pkg::retire_t actual,
                                input i8080_pkg::retire_t expected, input int index);
    compare_byte("retire_data.opcode", actual.opcode, expected.opcode, index);
    compare_byte("retire_data.a", actual.a, expected.a, index);
    compare_byte("retire_data.flags", actual.flags, expected.flags, index);
    compare_word("retire_data.bc", actual.bc, expected.bc, index);
    compare_word("retire_data.de", actual.de, expected.de, index);
    compare_word("retire_data.hl", actual.hl, expected.hl, index);
    compare_word("retire_data.sp", actual.sp, expected.sp, index);
  endtask

  task automatic check_retire();
    if (retire_valid) begin
      if (rx_idx >= send_idx) begin
        report_error("a retire record arrived with no instruction in flight");
      end else if (rx_idx + 1 > RETIRE_CREDITS + credits_given) begin
        report_error("retire_valid fired without a retire credit");
      end else begin
        compare_retire(retire_data, expect_q[rx_idx], rx_idx);
        rx_idx++;
        credit_owed++;
      end
    end
  endtask

  task automatic return_credit();
    retire_credit <= 1'b0;
    if (credit_gap > 0) begin
      credit_gap--;
    end else if (credit_owed > 0) begin
      retire_credit <= 1'b1;
      credit_owed--;
      credits_given++;
      credit_gap = take_bits(3);  // long gaps starve the core
    end
  endtask

  task automatic send_instr();
    instr_valid <= 1'b0;
    if (instr_credit) begin
      credits_seen++;
      send_credits++;
      if (credits_seen > send_idx || send_credits > INSTR_DEPTH) begin
        report_error("instr_credit pulsed more often than words were pushed");
      end
    end
    if (send_gap > 0) begin
      send_gap--;
    end else if (send_idx < n_lines && send_credits > 0) begin
      instr_valid <= 1'b1;
      instr_data  <= instr_q[send_idx];
      send_credits--;
      send_idx++;
      send_gap = take_bits(1) ? take_bits(2) : 0;
    end
  endtask

  initial begin : load_vectors
    int                     fd;
    int                     n;
    string                  line;
    logic [7:0]             op;
    logic [7:0]             imm;
    logic [7:0]             a;
    logic [7:0]             fl;
    logic [15:0]            bc;
    logic [15:0]            de;
    logic [15:0]            hl;
    logic [15:0]            sp;
    i8080_pkg::instr_word_t word;
    i8080_pkg::retire_t     rec;
    instr_valid   = 1'b0;
    instr_data    = '0;
    retire_credit = 1'b0;
    fd = $fopen("test/exec_input.txt", "r");
    if (fd == 0) begin
      report_error("cannot open test/exec_input.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line.getc(0) != "#") begin  // header lines skipped
          n = $sscanf(line, "%h %h %h %h %h %h %h %h", op, imm, a, fl, bc, de, hl, sp);
          if (n == 8) begin
            word.opcode = op;
            word.imm    = imm;
            instr_q.push_back(word);
            rec.opcode = op;
            rec.a      = a;
            rec.flags  = fl;
            rec.bc     = bc;
            rec.de     = de;
            rec.hl     = hl;
            rec.sp     = sp;
            expect_q.push_back(rec);
          end else if (n > 0) begin
            report_error("a line of test/exec_input.txt does not hold eight fields");
          end
        end
      end
      $fclose(fd);
      n_lines = instr_q.size();
      if (n_lines == 0) begin
        report_error("test/exec_input.txt holds no instructions");
      end else begin
        loaded = 1'b1;
      end
    end
  end

  always @(posedge clk) begin : traffic
    if (rst_n && loaded && !error_seen) begin
      check_retire();
      return_credit();
      send_instr();
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (n_lines * CYCLES_PER_LINE) @(posedge clk);
    $display("Timeout: %0d of %0d records retired within %0d cycles",
             rx_idx, n_lines, n_lines * CYCLES_PER_LINE);
    timed_out = 1'b1;
  end

  initial begin : run_end
    wait (error_seen || timed_out || (loaded && rx_idx == n_lines));
    if (!error_seen && !timed_out) begin
      repeat (DRAIN_CYCLES) @(posedge clk);  // a late extra record still gets caught
    end
    if (error_seen || timed_out) begin
      $display("Checks failed");
      $fatal(1, "simulation stopped on error");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end
endmodule

// File: test/tb_clock.sv
module tb_clock #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end
endmodule
